//--- verilog.f
common/fetch_pkg.sv
common/isa_pkg.sv
fetch/pc_unit.sv
design/inst_mem.sv
fetch/fetch_controller.sv
design/branch_predecode.sv
design/fetch_top.sv
dv/fetch_tb.sv

//--- dv/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;
  import fetch_pkg::*;
  import isa_pkg::*;

  localparam int IMG_WORDS  = 64;  // Words loaded per test.
  localparam int WAIT_LIMIT = 50;  // Cycles before a wait gives up.

  logic         clock;
  logic         reset;
  logic         prog_we_i;
  addr_t        prog_addr_i;
  inst_t        prog_data_i;
  logic         start_i;
  logic         inst_valid_o;
  logic         inst_ready_i;
  inst_t        inst_o;
  addr_t        inst_pc_o;
  logic         is_branch_o;
  fetch_state_e state_o;
  logic         resolve_valid_i;
  logic         resolve_taken_i;
  addr_t        resolve_target_i;

  inst_t        prog_img [IMG_WORDS];  // Program image with word i at byte 4*i.
  logic [31:0]  lfsr_q;
  int           error_count;
  int           check_count;

  fetch_top dut_i (.*);

  always #2 clock = ~clock;  // 4 ns period.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction builders and stall source.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic inst_t enc_addi(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, 7'b0010011};
  endfunction

  // B format drops imm bit 0.
  function automatic inst_t enc_branch(input logic [2:0] funct3, input imm_t imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, funct3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic inst_t enc_jal(input imm_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
  endfunction

  function automatic inst_t enc_jalr(input logic [11:0] imm);
    return {imm, 5'd5, 3'b000, 5'd1, OP_JALR};
  endfunction

  // Galois step with taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v      = (v << 1) | lfsr_q[0];  // One step per bit.
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helper tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset           <= 1'b1;
    start_i         <= 1'b0;
    inst_ready_i    <= 1'b0;
    resolve_valid_i <= 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
  endtask

  // Filler words are addi with rd and imm taken from the index.
  task automatic fill_image();
    for (int i = 0; i < IMG_WORDS; i++) begin
      prog_img[i] = enc_addi(5'(i + 1), 12'(i * 37 + 5));
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < IMG_WORDS; i++) begin
      @(posedge clock);
      prog_we_i   <= 1'b1;
      prog_addr_i <= addr_t'(i * 4);
      prog_data_i <= prog_img[i];
    end
    @(posedge clock);
    prog_we_i <= 1'b0;
  endtask

  task automatic start_fetch();
    @(posedge clock);
    start_i <= 1'b1;
    @(posedge clock);
    start_i <= 1'b0;  // Single cycle pulse.
  endtask

  // Waits for an offer, checks it, holds ready low for stall cycles, then accepts.
  task automatic accept_inst(input addr_t exp_pc, input inst_t exp_inst,
                             input logic exp_br, input int stall);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!inst_valid_o && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (!inst_valid_o) begin
      error_count++;
      $display("timeout waiting for inst_valid_o, expected pc %h", exp_pc);
    end else begin
      check_word("inst_pc_o", inst_pc_o, exp_pc);
      check_word("inst_o", inst_o, exp_inst);
      check_word("is_branch_o", 32'(is_branch_o), 32'(exp_br));
      repeat (stall) begin
        @(negedge clock);  // Offer must hold while stalled.
        check_word("inst_valid_o", 32'(inst_valid_o), 32'd1);
        check_word("inst_pc_o", inst_pc_o, exp_pc);
        check_word("inst_o", inst_o, exp_inst);
        check_word("is_branch_o", 32'(is_branch_o), 32'(exp_br));
        check_word("state_o", 32'(state_o), 32'(wait_ready));
      end
      @(posedge clock);
      inst_ready_i <= 1'b1;
      @(posedge clock);
      inst_ready_i <= 1'b0;  // Taken on this edge.
    end
  endtask

  // Fetch must stay quiet until the resolve pulse.
  task automatic resolve_branch(input logic taken, input addr_t target);
    repeat (3) begin
      @(negedge clock);
      check_word("inst_valid_o", 32'(inst_valid_o), 32'd0);
      check_word("state_o", 32'(state_o), 32'(wait_branch));
    end
    @(posedge clock);
    resolve_valid_i  <= 1'b1;
    resolve_taken_i  <= taken;
    resolve_target_i <= target;
    @(posedge clock);
    resolve_valid_i <= 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_word("inst_valid_o", 32'(inst_valid_o), 32'd0);
      check_word("state_o", 32'(state_o), 32'(idle));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_straight_line();
    apply_reset();
    fill_image();
    load_program();
    check_idle(4);  // Nothing moves before start.
    start_fetch();
    for (int i = 0; i < 8; i++) begin
      accept_inst(RESET_PC + addr_t'(i * 4), prog_img[i], 1'b0, 0);
    end
  endtask

  task automatic test_random_stalls();
    apply_reset();
    fill_image();
    load_program();
    start_fetch();
    for (int i = 0; i < 12; i++) begin
      accept_inst(RESET_PC + addr_t'(i * 4), prog_img[i], 1'b0, rand_bits(3));
    end
  endtask

  task automatic test_cond_branch();
    apply_reset();
    fill_image();
    prog_img[1] = enc_branch(3'b000, imm_t'(16));  // beq at 0x04.
    prog_img[6] = enc_branch(3'b001, -imm_t'(8));  // bne at 0x18.
    load_program();
    start_fetch();
    accept_inst(32'h00, prog_img[0], 1'b0, 0);
    accept_inst(32'h04, prog_img[1], 1'b1, 1);
    resolve_branch(1'b1, 32'h0000_0080);           // Target input unused here.
    accept_inst(32'h04 + imm_t'(16), prog_img[5], 1'b0, 0);
    accept_inst(32'h18, prog_img[6], 1'b1, 2);
    resolve_branch(1'b0, 32'h0000_0080);
    accept_inst(32'h18 + 32'd4, prog_img[7], 1'b0, 0);  // Fall through.
  endtask

  task automatic test_jumps();
    apply_reset();
    fill_image();
    prog_img[0]  = enc_jal(imm_t'(12));
    prog_img[3]  = enc_jalr(12'h010);
    prog_img[16] = enc_jal(-imm_t'(32));  // Backward jump at 0x40.
    load_program();
    start_fetch();
    accept_inst(32'h00, prog_img[0], 1'b1, 0);
    resolve_branch(1'b0, 32'h0000_0100);  // JAL goes anyway.
    accept_inst(32'h00 + imm_t'(12), prog_img[3], 1'b1, 0);
    resolve_branch(1'b1, 32'h0000_0040);
    accept_inst(32'h40, prog_img[16], 1'b1, 1);
    resolve_branch(1'b1, 32'h0000_0000);
    accept_inst(32'h40 - 32'd32, prog_img[8], 1'b0, 0);
  endtask

  task automatic test_mid_reset();
    apply_reset();
    fill_image();
    load_program();
    start_fetch();
    for (int i = 0; i < 3; i++) begin
      accept_inst(RESET_PC + addr_t'(i * 4), prog_img[i], 1'b0, 0);
    end
    apply_reset();  // Lands while the next read is in flight.
    check_idle(3);
    start_fetch();
    accept_inst(RESET_PC, prog_img[0], 1'b0, 0);
    accept_inst(RESET_PC + 32'd4, prog_img[1], 1'b0, 0);
  endtask

  initial begin
    clock            = 1'b0;
    reset            = 1'b1;
    prog_we_i        = 1'b0;
    prog_addr_i      = '0;
    prog_data_i      = '0;
    start_i          = 1'b0;
    inst_ready_i     = 1'b0;
    resolve_valid_i  = 1'b0;
    resolve_taken_i  = 1'b0;
    resolve_target_i = '0;
    lfsr_q           = 32'd68376;
    error_count      = 0;
    check_count      = 0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    check_idle(10);  // Idle with no start after power-up.
    test_straight_line();
    test_random_stalls();
    test_cond_branch();
    test_jumps();
    test_mid_reset();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
  input  logic                    clock,
  input  logic                    reset,

  // Program load.
  input  logic                    prog_we_i,
  input  fetch_pkg::addr_t        prog_addr_i,
  input  fetch_pkg::inst_t        prog_data_i,

  input  logic                    start_i,           // One-cycle start pulse.

  // Instruction out to decode.
  output logic                    inst_valid_o,
  input  logic                    inst_ready_i,
  output fetch_pkg::inst_t        inst_o,
  output fetch_pkg::addr_t        inst_pc_o,
  output logic                    is_branch_o,
  output fetch_pkg::fetch_state_e state_o,

  // Branch resolution from execute.
  input  logic                    resolve_valid_i,
  input  logic                    resolve_taken_i,
  input  fetch_pkg::addr_t        resolve_target_i
);
  import fetch_pkg::*;

  addr_t pc;               // Read address.
  logic  arvalid;
  logic  arready;
  logic  rvalid;
  logic  rready;
  inst_t rdata;
  logic  inst_we;          // Read beat, latch into predecode.
  logic  pc_we;
  logic  branch_inst;
  logic  branch_valid;
  logic  redirect_valid;
  addr_t redirect_target;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline: PC, memory, controller, predecode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  pc_unit pc_unit_i (
    .clock             (clock),
    .reset             (reset),
    .pc_we_i           (pc_we),
    .redirect_valid_i  (redirect_valid),
    .redirect_target_i (redirect_target),
    .pc_o              (pc)
  );

  inst_mem inst_mem_i (
    .clock       (clock),
    .reset       (reset),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .araddr_i    (pc),
    .rvalid_o    (rvalid),
    .rready_i    (rready),
    .rdata_o     (rdata)
  );

  fetch_controller fetch_controller_i (
    .clock          (clock),
    .reset          (reset),
    .firing_i       (start_i),
    .arready_i      (arready),
    .arvalid_o      (arvalid),
    .rvalid_i       (rvalid),
    .rready_o       (rready),
    .valid_post_o   (inst_valid_o),
    .ready_post_i   (inst_ready_i),
    .branch_inst_i  (branch_inst),
    .branch_valid_i (branch_valid),
    .inst_we_o      (inst_we),
    .pc_we_o        (pc_we),
    .state_o        (state_o)
  );

  branch_predecode branch_predecode_i (
    .clock             (clock),
    .reset             (reset),
    .inst_we_i         (inst_we),
    .rdata_i           (rdata),
    .pc_i              (pc),
    .resolve_valid_i   (resolve_valid_i),
    .resolve_taken_i   (resolve_taken_i),
    .resolve_target_i  (resolve_target_i),
    .inst_o            (inst_o),
    .inst_pc_o         (inst_pc_o),
    .branch_inst_o     (branch_inst),
    .branch_valid_o    (branch_valid),
    .redirect_valid_o  (redirect_valid),
    .redirect_target_o (redirect_target)
  );

  assign is_branch_o = branch_inst;  // Also steers the controller.

endmodule

//--- design/branch_predecode.sv
`timescale 1ns/10ps

module branch_predecode (
  input  logic             clock,
  input  logic             reset,

  // Read beat from memory.
  input  logic             inst_we_i,
  input  fetch_pkg::inst_t rdata_i,
  input  fetch_pkg::addr_t pc_i,              // Address the word came from.

  // Resolution from the back end.
  input  logic             resolve_valid_i,
  input  logic             resolve_taken_i,
  input  fetch_pkg::addr_t resolve_target_i,  // JALR target.

  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t inst_pc_o,
  output logic             branch_inst_o,     // Latched word is a control transfer.
  output logic             branch_valid_o,    // Resolve seen, release fetch.
  output logic             redirect_valid_o,
  output fetch_pkg::addr_t redirect_target_o
);
  import fetch_pkg::*;
  import isa_pkg::*;

  opcode_t opcode;
  imm_t    imm_b;
  imm_t    imm_j;
  imm_t    imm_sel;
  logic    dec_cond;
  logic    dec_jal;
  logic    dec_jalr;
  inst_t   inst_q;
  addr_t   pc_q;
  addr_t   target_q;   // pc plus immediate, held until resolve.
  addr_t   seq_pc;
  logic    cond_q;
  logic    jal_q;
  logic    jalr_q;
  logic    pending_q;  // Transfer waiting for its resolve.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Classify and build immediates from the incoming word.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opcode   = rdata_i[6:0];
  assign dec_cond = (opcode == OP_BRANCH);
  assign dec_jal  = (opcode == OP_JAL);
  assign dec_jalr = (opcode == OP_JALR);

  // B format, bit 0 implied zero.
  assign imm_b = {{19{rdata_i[31]}}, rdata_i[31], rdata_i[7],
                  rdata_i[30:25], rdata_i[11:8], 1'b0};
  // J format.
  assign imm_j = {{11{rdata_i[31]}}, rdata_i[31], rdata_i[19:12],
                  rdata_i[20], rdata_i[30:21], 1'b0};
  assign imm_sel = dec_jal ? imm_j : imm_b;  // Unused for JALR.

  // Instruction register and target, payload only.
  always_ff @(posedge clock) begin
    if (inst_we_i) begin
      inst_q   <= rdata_i;
      pc_q     <= pc_i;
      target_q <= pc_i + addr_t'(imm_sel);
    end
  end

  // Class flags and the pending hold.
  always_ff @(posedge clock) begin
    if (reset) begin
      cond_q    <= 1'b0;
      jal_q     <= 1'b0;
      jalr_q    <= 1'b0;
      pending_q <= 1'b0;
    end else if (inst_we_i) begin
      cond_q    <= dec_cond;
      jal_q     <= dec_jal;
      jalr_q    <= dec_jalr;
      pending_q <= dec_cond || dec_jal || dec_jalr;
    end else if (resolve_valid_i) begin
      pending_q <= 1'b0;  // One resolve per transfer.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Resolution and redirect.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign seq_pc           = pc_q + 32'd4;
  assign branch_valid_o   = resolve_valid_i && pending_q;
  assign redirect_valid_o = branch_valid_o;  // PC loads on the same edge as the FSM moves.

  always_comb begin
    if (jalr_q) begin
      redirect_target_o = resolve_target_i;  // Register based, from execute.
    end else if (jal_q || (cond_q && resolve_taken_i)) begin
      redirect_target_o = target_q;          // JAL ignores the taken bit.
    end else begin
      redirect_target_o = seq_pc;            // Not taken, fall through.
    end
  end

  assign inst_o        = inst_q;
  assign inst_pc_o     = pc_q;
  assign branch_inst_o = cond_q || jal_q || jalr_q;

endmodule

//--- fetch/fetch_controller.sv
`timescale 1ns/10ps

module fetch_controller (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    firing_i,        // Start pulse.

  // Instruction memory request and response.
  input  logic                    arready_i,
  output logic                    arvalid_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,

  // Decode side hand-off.
  output logic                    valid_post_o,
  input  logic                    ready_post_i,
  input  logic                    branch_inst_i,   // Latched word is a control transfer.
  input  logic                    branch_valid_i,  // Control transfer resolved.

  output logic                    inst_we_o,       // Latch strobe for predecode.
  output logic                    pc_we_o,         // Sequential PC step.
  output fetch_pkg::fetch_state_e state_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Outputs decoded from the current state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign arvalid_o    = (state_q == wait_arready);  // Held until arready.
  assign rready_o     = (state_q == wait_rvalid);
  assign valid_post_o = (state_q == wait_ready);    // Held until accepted.
  assign inst_we_o    = rvalid_i && rready_o;       // Read beat.
  assign state_o      = state_q;

  // Only a plain instruction steps the PC, a transfer waits for resolve.
  assign pc_we_o = valid_post_o && ready_post_i && !branch_inst_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state, one edge per transition.
  always_comb begin
    state_d = state_q;  // Hold by default.
    case (state_q)
      idle: begin
        if (firing_i) state_d = wait_arready;
      end
      wait_arready: begin
        if (arready_i) state_d = wait_rvalid;  // Address taken.
      end
      wait_rvalid: begin
        if (rvalid_i) state_d = wait_ready;    // Word latched.
      end
      wait_ready: begin
        if (ready_post_i) begin
          if (branch_inst_i) begin
            state_d = wait_branch;   // Stall fetch until resolve.
          end else begin
            state_d = wait_arready;  // Next sequential word.
          end
        end
      end
      wait_branch: begin
        if (branch_valid_i) state_d = wait_arready;  // PC redirected this edge.
      end
      default: state_d = idle;
    endcase
  end

endmodule

//--- design/inst_mem.sv
`timescale 1ns/10ps

module inst_mem (
  input  logic             clock,
  input  logic             reset,

  // Program load port, used before start only.
  input  logic             prog_we_i,
  input  fetch_pkg::addr_t prog_addr_i,  // Byte address, low two bits ignored.
  input  fetch_pkg::inst_t prog_data_i,

  // Read channel.
  input  logic             arvalid_i,
  output logic             arready_o,
  input  fetch_pkg::addr_t araddr_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output fetch_pkg::inst_t rdata_o
);
  import fetch_pkg::*;

  inst_t                 mem [MEM_WORDS];  // Word storage.
  logic [MEM_ADDR_W-1:0] wr_idx;
  logic [MEM_ADDR_W-1:0] rd_idx;
  logic                  busy_q;           // Read slot occupied.
  logic [LAT_CNT_W-1:0]  lat_cnt_q;        // Cycles left before the beat.
  inst_t                 rdata_q;
  logic                  ar_fire;
  logic                  r_fire;

  // Word index, byte offset dropped.
  assign wr_idx = prog_addr_i[MEM_ADDR_W+1:2];
  assign rd_idx = araddr_i[MEM_ADDR_W+1:2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshakes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign arready_o = !busy_q;                      // One read in flight at most.
  assign ar_fire   = arvalid_i && arready_o;
  assign rvalid_o  = busy_q && (lat_cnt_q == '0);  // Held until rready.
  assign r_fire    = rvalid_o && rready_i;
  assign rdata_o   = rdata_q;

  // Load port.
  always_ff @(posedge clock) begin
    if (prog_we_i) begin
      mem[wr_idx] <= prog_data_i;
    end
  end

  // Word sampled on address accept, shown once the delay runs out.
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata_q <= mem[rd_idx];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Latency counter and slot state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Accept at the edge ending cycle t, beat in cycle t + MEM_LATENCY.
  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q    <= 1'b0;
      lat_cnt_q <= '0;
    end else if (ar_fire) begin
      busy_q    <= 1'b1;
      lat_cnt_q <= LAT_CNT_W'(MEM_LATENCY - 1);
    end else begin
      if (lat_cnt_q != '0) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;  // Count down while waiting.
      end
      if (r_fire) begin
        busy_q <= 1'b0;                 // Slot free, arready returns.
      end
    end
  end

endmodule

//--- fetch/pc_unit.sv
`timescale 1ns/10ps

module pc_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             pc_we_i,            // Step to next word.
  input  logic             redirect_valid_i,   // Load resolved target.
  input  fetch_pkg::addr_t redirect_target_i,
  output fetch_pkg::addr_t pc_o                // Current fetch address.
);
  import fetch_pkg::*;

  addr_t pc_q;
  addr_t seq_pc;  // Sequential successor.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next address.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign seq_pc = pc_q + 32'd4;  // RV32I words are four bytes.

  // Redirect and step are mutually exclusive.
  // Step comes from a plain hand-off, redirect only from the branch wait.
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;  // Fetch restarts here on the next start.
    end else if (redirect_valid_i) begin
      pc_q <= redirect_target_i;
    end else if (pc_we_i) begin
      pc_q <= seq_pc;
    end
  end

  // PC holds through every other cycle, so the read address is stable
  // for the whole request.
  assign pc_o = pc_q;

endmodule

//--- common/isa_pkg.sv
package isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RV32I field types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Major opcode lives in bits [6:0] of every instruction.
  typedef logic [6:0] opcode_t;

  // Immediates are always sign extended to a full word.
  typedef logic [31:0] imm_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control-transfer opcodes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Conditional branches, B format.
  // Covers beq, bne, blt, bge, bltu and bgeu, funct3 picks which.
  // Target is pc plus the B immediate, decided by execute.
  localparam opcode_t OP_BRANCH = 7'b1100011;

  // Jump and link, J format.
  // Always taken, target is pc plus the J immediate.
  localparam opcode_t OP_JAL = 7'b1101111;

  // Jump and link register, I format.
  // Target depends on rs1, so only execute knows it.
  localparam opcode_t OP_JALR = 7'b1100111;

  // Immediate layouts, for reference.
  // B : imm[12|10:5] in [31:25], imm[4:1|11] in [11:7].
  // J : imm[20|10:1|11|19:12] in [31:12].
  // Bit 0 of both is implied zero.

endpackage

//--- common/fetch_pkg.sv
package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch side widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] addr_t;  // Byte address of an instruction.
  typedef logic [31:0] inst_t;  // One raw instruction word.

  // First address fetched after reset.
  localparam addr_t RESET_PC = 32'h0000_0000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction memory geometry and timing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int MEM_WORDS   = 256;  // Depth in words.
  localparam int MEM_ADDR_W  = 8;    // Word index width.
  localparam int MEM_LATENCY = 2;    // Cycles from accepted address to read data.

  // Latency down-counter width.
  localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch controller states.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Three-bit state codes.
  typedef enum logic [2:0] {
    idle         = 3'b000,  // Waiting for the start pulse.
    wait_ready   = 3'b001,  // Instruction offered to decode.
    wait_arready = 3'b010,  // Address request outstanding.
    wait_rvalid  = 3'b011,  // Waiting for the read beat.
    wait_branch  = 3'b100   // Control transfer handed off and waiting for resolve.
  } fetch_state_e;

endpackage
